/* rv_fetch_defines.svh */
`ifndef RV_FETCH_DEFINES_SVH
`define RV_FETCH_DEFINES_SVH

// width of an instruction address
`define RV_XLEN 32

// log2 of the number of BTB entries
`define RV_BTB_IDX_BITS 4

// log2 of the instruction memory depth in words
// the memory is indexed by address bits [RV_IMEM_ADDR_BITS+1:2]
`define RV_IMEM_ADDR_BITS 8

// first address fetched once reset is released
`define RV_RESET_VECTOR 32'h0000_0100

`endif

/* rv_fetch_pkg.sv */
`default_nettype none

`include "rv_fetch_defines.svh"

package rv_fetch_pkg;

    // instruction address
    typedef logic [`RV_XLEN-1:0] pc_t;

    // an instruction word is always 32 bits since compressed forms are not fetched
    typedef logic [31:0] instr_t;

    // per-entry direction counter of the BTB
    // an entry predicts taken from CTR_WEAK_T upward
    typedef enum logic [1:0] {
        CTR_STRONG_NT = 2'b00,
        CTR_WEAK_NT   = 2'b01,
        CTR_WEAK_T    = 2'b10,
        CTR_STRONG_T  = 2'b11
    } ctr_e;

endpackage

`default_nettype wire

/* rv_fetch_branch_pred.sv */
`default_nettype none

`include "rv_fetch_defines.svh"

module rv_fetch_branch_pred
#(
    parameter int TABLE_SIZE_BITS = `RV_BTB_IDX_BITS
)
(
    input  wire logic               i_clk,
    input  wire logic               i_reset_n,
    input  wire rv_fetch_pkg::pc_t  i_lookup_pc,
    output logic                    o_hit,
    output rv_fetch_pkg::pc_t       o_target,
    input  wire logic               i_update_valid,
    input  wire rv_fetch_pkg::pc_t  i_update_pc,
    input  wire rv_fetch_pkg::pc_t  i_update_target,
    input  wire logic               i_update_taken
);

    import rv_fetch_pkg::*;

    localparam int TABLE_SIZE = 2 ** TABLE_SIZE_BITS;

    logic [TABLE_SIZE-1:0]      entry_valid;
    pc_t                        entry_tag    [TABLE_SIZE];
    pc_t                        entry_target [TABLE_SIZE];
    ctr_e                       entry_ctr    [TABLE_SIZE];

    logic [TABLE_SIZE_BITS-1:0] rr_ptr;
    logic [TABLE_SIZE_BITS-1:0] upd_idx;
    logic                       upd_hit;
    logic                       alloc;
    logic                       train;

    // one step of the saturating counter toward the resolved direction
    function automatic ctr_e ctr_step(input ctr_e cur, input logic taken);
        ctr_e nxt;
        case (cur)
            CTR_STRONG_NT: nxt = taken ? CTR_WEAK_NT  : CTR_STRONG_NT;
            CTR_WEAK_NT:   nxt = taken ? CTR_WEAK_T   : CTR_STRONG_NT;
            CTR_WEAK_T:    nxt = taken ? CTR_STRONG_T : CTR_WEAK_NT;
            default:       nxt = taken ? CTR_STRONG_T : CTR_WEAK_T;
        endcase
        return nxt;
    endfunction

    // parallel tag compare; scanning downward leaves the lowest matching index
    always_comb
    begin
        o_hit    = 1'b0;
        o_target = '0;
        for (int i = TABLE_SIZE - 1; i >= 0; i--)
        begin
            if (entry_valid[i] && (entry_tag[i] == i_lookup_pc) &&
                (entry_ctr[i] inside {CTR_WEAK_T, CTR_STRONG_T}))
            begin
                o_hit    = 1'b1;
                o_target = entry_target[i];
            end
        end
    end

    // training looks for the address regardless of the counter state
    always_comb
    begin
        upd_hit = 1'b0;
        upd_idx = '0;
        for (int i = TABLE_SIZE - 1; i >= 0; i--)
        begin
            if (entry_valid[i] && (entry_tag[i] == i_update_pc))
            begin
                upd_hit = 1'b1;
                upd_idx = TABLE_SIZE_BITS'(i);
            end
        end
    end

    assign train = i_update_valid && upd_hit;

    // a not-taken branch that is not in the table is not worth a slot
    assign alloc = i_update_valid && !upd_hit && i_update_taken;

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            entry_valid <= '0;
            rr_ptr      <= '0;
            for (int i = 0; i < TABLE_SIZE; i++)
            begin
                entry_ctr[i] <= CTR_STRONG_NT;
            end
        end
        else if (alloc)
        begin
            entry_valid[rr_ptr] <= 1'b1;
            entry_ctr[rr_ptr]   <= CTR_WEAK_T;
            // pointer width makes the wrap implicit
            rr_ptr              <= rr_ptr + 1'b1;
        end
        else if (train)
        begin
            entry_ctr[upd_idx] <= ctr_step(entry_ctr[upd_idx], i_update_taken);
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (alloc)
        begin
            entry_tag[rr_ptr]    <= i_update_pc;
            entry_target[rr_ptr] <= i_update_target;
        end
        else if (train)
        begin
            entry_target[upd_idx] <= i_update_target;
        end
    end

endmodule

`default_nettype wire

/* rv_fetch_imem.sv */
`default_nettype none

`include "rv_fetch_defines.svh"

module rv_fetch_imem
(
    input  wire logic                          i_clk,
    input  wire logic                          i_rd_en,
    input  wire rv_fetch_pkg::pc_t             i_rd_pc,
    output rv_fetch_pkg::instr_t               o_rd_data,
    input  wire logic                          i_wr_en,
    input  wire logic [`RV_IMEM_ADDR_BITS-1:0] i_wr_addr,
    input  wire rv_fetch_pkg::instr_t          i_wr_data
);

    import rv_fetch_pkg::*;

    localparam int DEPTH = 2 ** `RV_IMEM_ADDR_BITS;

    instr_t                         mem [DEPTH];
    logic [`RV_IMEM_ADDR_BITS-1:0]  rd_idx;

    // the word index drops the byte offset and lets the upper address bits wrap
    assign rd_idx = i_rd_pc[`RV_IMEM_ADDR_BITS+1:2];

    // load port used to fill the program before reset is released
    always_ff @(posedge i_clk)
    begin
        if (i_wr_en)
        begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    // read register only moves when fetch advances, so it holds under stall
    always_ff @(posedge i_clk)
    begin
        if (i_rd_en)
        begin
            o_rd_data <= mem[rd_idx];
        end
    end

endmodule

`default_nettype wire

/* rv_fetch_pc_gen.sv */
`default_nettype none

`include "rv_fetch_defines.svh"

module rv_fetch_pc_gen
(
    input  wire logic               i_clk,
    input  wire logic               i_reset_n,
    input  wire logic               i_btb_hit,
    input  wire rv_fetch_pkg::pc_t  i_btb_target,
    output rv_fetch_pkg::pc_t       o_pc,
    output logic                    o_advance,
    input  wire logic               i_redirect_valid,
    input  wire rv_fetch_pkg::pc_t  i_redirect_pc,
    output logic                    o_fetch_valid,
    input  wire logic               i_fetch_ready,
    output rv_fetch_pkg::pc_t       o_fetch_pc,
    output logic                    o_fetch_predicted
);

    import rv_fetch_pkg::*;

    pc_t  pc_q;
    pc_t  next_pc;
    logic out_valid_q;
    pc_t  out_pc_q;
    logic out_pred_q;
    logic advance;

    // the output slot frees up when empty or when decode takes it this cycle
    // a redirect always moves the pipe since the held item is dropped anyway
    assign advance = !out_valid_q || i_fetch_ready || i_redirect_valid;

    always_comb
    begin
        if (i_redirect_valid)
        begin
            next_pc = i_redirect_pc;
        end
        else if (i_btb_hit)
        begin
            next_pc = i_btb_target;
        end
        else
        begin
            next_pc = o_pc + pc_t'(4);
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            pc_q <= `RV_RESET_VECTOR;
        end
        else if (advance)
        begin
            pc_q <= next_pc;
        end
    end

    // the valid bit is flushed on a redirect, the fetch in flight is wrong path
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            out_valid_q <= 1'b0;
        end
        else if (i_redirect_valid)
        begin
            out_valid_q <= 1'b0;
        end
        else if (advance)
        begin
            out_valid_q <= 1'b1;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (advance)
        begin
            out_pc_q   <= pc_q;
            out_pred_q <= i_btb_hit;
        end
    end

    assign o_pc              = pc_q;
    assign o_advance         = advance;
    assign o_fetch_valid     = out_valid_q;
    assign o_fetch_pc        = out_pc_q;
    assign o_fetch_predicted = out_pred_q;

endmodule

`default_nettype wire

/* rv_fetch_top.sv */
`default_nettype none

`include "rv_fetch_defines.svh"

module rv_fetch_top
(
    input  wire logic                          i_clk,
    input  wire logic                          i_reset_n,
    output logic                               o_fetch_valid,
    input  wire logic                          i_fetch_ready,
    output rv_fetch_pkg::pc_t                  o_fetch_pc,
    output rv_fetch_pkg::instr_t               o_fetch_instr,
    output logic                               o_fetch_predicted,
    input  wire logic                          i_redirect_valid,
    input  wire rv_fetch_pkg::pc_t             i_redirect_pc,
    input  wire logic                          i_update_valid,
    input  wire rv_fetch_pkg::pc_t             i_update_pc,
    input  wire rv_fetch_pkg::pc_t             i_update_target,
    input  wire logic                          i_update_taken,
    input  wire logic                          i_imem_wr_en,
    input  wire logic [`RV_IMEM_ADDR_BITS-1:0] i_imem_wr_addr,
    input  wire rv_fetch_pkg::instr_t          i_imem_wr_data
);

    import rv_fetch_pkg::*;

    pc_t  fetch_pc;
    pc_t  btb_target;
    logic btb_hit;
    logic advance;

    rv_fetch_pc_gen u_pc_gen
    (
        .i_clk             (i_clk),
        .i_reset_n         (i_reset_n),
        .i_btb_hit         (btb_hit),
        .i_btb_target      (btb_target),
        .o_pc              (fetch_pc),
        .o_advance         (advance),
        .i_redirect_valid  (i_redirect_valid),
        .i_redirect_pc     (i_redirect_pc),
        .o_fetch_valid     (o_fetch_valid),
        .i_fetch_ready     (i_fetch_ready),
        .o_fetch_pc        (o_fetch_pc),
        .o_fetch_predicted (o_fetch_predicted)
    );

    rv_fetch_branch_pred
    #(
        .TABLE_SIZE_BITS (`RV_BTB_IDX_BITS)
    )
    u_btb
    (
        .i_clk           (i_clk),
        .i_reset_n       (i_reset_n),
        .i_lookup_pc     (fetch_pc),
        .o_hit           (btb_hit),
        .o_target        (btb_target),
        .i_update_valid  (i_update_valid),
        .i_update_pc     (i_update_pc),
        .i_update_target (i_update_target),
        .i_update_taken  (i_update_taken)
    );

    // the read register lines up with the output register since both load on advance
    rv_fetch_imem u_imem
    (
        .i_clk     (i_clk),
        .i_rd_en   (advance),
        .i_rd_pc   (fetch_pc),
        .o_rd_data (o_fetch_instr),
        .i_wr_en   (i_imem_wr_en),
        .i_wr_addr (i_imem_wr_addr),
        .i_wr_data (i_imem_wr_data)
    );

endmodule

`default_nettype wire

/* tb_rv_fetch.sv */
`default_nettype none

`include "rv_fetch_defines.svh"

module tb_rv_fetch;

    timeunit 1ns;
    timeprecision 1ps;

    import rv_fetch_pkg::*;

    localparam int BTB_SIZE   = 2 ** `RV_BTB_IDX_BITS;
    localparam int IMEM_WORDS = 2 ** `RV_IMEM_ADDR_BITS;

    logic                          i_clk;
    logic                          i_reset_n;
    logic                          i_fetch_ready;
    logic                          i_redirect_valid;
    logic                          i_update_valid;
    logic                          i_update_taken;
    logic                          i_imem_wr_en;
    logic [`RV_IMEM_ADDR_BITS-1:0] i_imem_wr_addr;
    instr_t                        i_imem_wr_data;
    pc_t                           i_redirect_pc;
    pc_t                           i_update_pc;
    pc_t                           i_update_target;
    logic                          o_fetch_valid;
    logic                          o_fetch_predicted;
    pc_t                           o_fetch_pc;
    instr_t                        o_fetch_instr;

    // BTB model and expected stream
    logic [BTB_SIZE-1:0] m_valid;
    pc_t                 m_tag    [BTB_SIZE];
    pc_t                 m_target [BTB_SIZE];
    int                  m_ctr    [BTB_SIZE];
    int                  m_rr;
    pc_t                 exp_pc;

    logic [31:0] lfsr_state;
    string       test_name;
    int          pred_seen;
    int          value_errors;
    int          hold_errors;
    int          reset_errors;
    int          timeout_errors;
    bit          timed_out;
    bit          was_stalled;
    bit          was_redirect;
    pc_t         held_pc;
    instr_t      held_instr;
    logic        held_pred;

    rv_fetch_top dut0
    (
        .i_clk             (i_clk),
        .i_reset_n         (i_reset_n),
        .o_fetch_valid     (o_fetch_valid),
        .i_fetch_ready     (i_fetch_ready),
        .o_fetch_pc        (o_fetch_pc),
        .o_fetch_instr     (o_fetch_instr),
        .o_fetch_predicted (o_fetch_predicted),
        .i_redirect_valid  (i_redirect_valid),
        .i_redirect_pc     (i_redirect_pc),
        .i_update_valid    (i_update_valid),
        .i_update_pc       (i_update_pc),
        .i_update_target   (i_update_target),
        .i_update_taken    (i_update_taken),
        .i_imem_wr_en      (i_imem_wr_en),
        .i_imem_wr_addr    (i_imem_wr_addr),
        .i_imem_wr_data    (i_imem_wr_data)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    // valid has to stay low for as long as reset is held
    assert property (@(posedge i_clk) !i_reset_n |=> !o_fetch_valid)
    else
    begin
        reset_errors++;
        $display("[FAIL] reset: expected valid 0 actual %b", $sampled(o_fetch_valid));
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0])
        begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    // every word holds its byte address XOR a marker, and memory wraps every 1 KiB
    function automatic instr_t word_at(input pc_t pc);
        return instr_t'(pc % (4 * IMEM_WORDS)) ^ 32'hA5A5_0000;
    endfunction

    // lowest valid matching entry that leans taken wins
    function automatic logic model_hit(input pc_t pc, output pc_t tgt);
        logic hit;
        hit = 1'b0;
        tgt = '0;
        for (int i = 0; i < BTB_SIZE; i++)
        begin
            if (!hit && m_valid[i] && m_tag[i] == pc && m_ctr[i] >= 2)
            begin
                hit = 1'b1;
                tgt = m_target[i];
            end
        end
        return hit;
    endfunction

    task automatic model_train(input pc_t pc, input pc_t tgt, input logic taken);
        int idx;
        idx = -1;
        for (int i = 0; i < BTB_SIZE; i++)
        begin
            if (idx < 0 && m_valid[i] && m_tag[i] == pc)
            begin
                idx = i;
            end
        end
        if (idx >= 0)
        begin
            m_target[idx] = tgt;
            if (taken && m_ctr[idx] < 3)
            begin
                m_ctr[idx]++;
            end
            else if (!taken && m_ctr[idx] > 0)
            begin
                m_ctr[idx]--;
            end
        end
        else if (taken)
        begin
            m_valid[m_rr]  = 1'b1;
            m_tag[m_rr]    = pc;
            m_target[m_rr] = tgt;
            m_ctr[m_rr]    = 2;
            m_rr           = (m_rr + 1) % BTB_SIZE;
        end
    endtask

    // drop the one-cycle commands on the falling edge and check what the last rising edge did
    task automatic next_negedge();
        @(negedge i_clk);
        i_redirect_valid = 1'b0;
        i_update_valid   = 1'b0;
        if (was_redirect)
        begin
            assert (o_fetch_valid === 1'b0)
            else
            begin
                value_errors++;
                $display("[FAIL] %s flush: expected valid 0 actual %b", test_name, o_fetch_valid);
            end
        end
        if (was_stalled)
        begin
            assert (o_fetch_valid === 1'b1 && o_fetch_pc === held_pc &&
                    o_fetch_instr === held_instr && o_fetch_predicted === held_pred)
            else
            begin
                hold_errors++;
                $display("[FAIL] %s hold pc/instr/pred: expected %h %h %b actual %h %h %b valid %b",
                         test_name, held_pc, held_instr, held_pred, o_fetch_pc, o_fetch_instr,
                         o_fetch_predicted, o_fetch_valid);
            end
        end
    endtask

    task automatic note_outputs();
        was_stalled  = (o_fetch_valid === 1'b1) && !i_fetch_ready && !i_redirect_valid;
        was_redirect = i_redirect_valid;
        held_pc      = o_fetch_pc;
        held_instr   = o_fetch_instr;
        held_pred    = o_fetch_predicted;
    endtask

    task automatic check_item();
        pc_t  tgt;
        logic hit;
        hit = model_hit(exp_pc, tgt);
        assert (o_fetch_pc === exp_pc)
        else
        begin
            value_errors++;
            $display("[FAIL] %s pc: expected %h actual %h", test_name, exp_pc, o_fetch_pc);
        end
        assert (o_fetch_instr === word_at(exp_pc))
        else
        begin
            value_errors++;
            $display("[FAIL] %s instr: expected %h actual %h", test_name, word_at(exp_pc),
                     o_fetch_instr);
        end
        assert (o_fetch_predicted === hit)
        else
        begin
            value_errors++;
            $display("[FAIL] %s predicted: expected %b actual %b", test_name, hit,
                     o_fetch_predicted);
        end
        if (o_fetch_predicted === 1'b1)
        begin
            pred_seen++;
        end
        exp_pc = hit ? tgt : pc_t'(exp_pc + 32'd4);
    endtask

    task automatic accept_items(input string name, input int count, input bit random_ready);
        int   got;
        int   cycles;
        logic rdy;
        test_name = name;
        pred_seen = 0;
        got       = 0;
        cycles    = 0;
        while (!timed_out && got < count)
        begin
            next_negedge();
            rdy = 1'b1;
            if (random_ready)
            begin
                lfsr_state = lfsr_step(lfsr_state);
                rdy        = lfsr_state[0];
            end
            i_fetch_ready = rdy;
            if (o_fetch_valid === 1'b1 && rdy)
            begin
                check_item();
                got++;
            end
            note_outputs();
            cycles++;
            if (got < count && cycles >= count * 16 + 64)
            begin
                timed_out = 1'b1;
                timeout_errors++;
                $display("%s timed out: only %0d of %0d items accepted in %0d cycles",
                         name, got, count, cycles);
            end
        end
    endtask

    task automatic wait_for_valid_stalled(input string name);
        int cycles;
        bit done;
        test_name = name;
        cycles    = 0;
        done      = 1'b0;
        while (!timed_out && !done)
        begin
            next_negedge();
            i_fetch_ready = 1'b0;
            done = (o_fetch_valid === 1'b1);
            note_outputs();
            cycles++;
            if (!done && cycles >= 32)
            begin
                timed_out = 1'b1;
                timeout_errors++;
                $display("%s timed out: the output never became valid", name);
            end
        end
    endtask

    task automatic redirect_to(input pc_t pc);
        next_negedge();
        i_fetch_ready    = 1'b0;
        i_redirect_valid = 1'b1;
        i_redirect_pc    = pc;
        exp_pc           = pc;
        note_outputs();
    endtask

    task automatic train(input pc_t pc, input pc_t tgt, input logic taken);
        next_negedge();
        i_fetch_ready   = 1'b0;
        i_update_valid  = 1'b1;
        i_update_pc     = pc;
        i_update_target = tgt;
        i_update_taken  = taken;
        model_train(pc, tgt, taken);
        note_outputs();
    endtask

    task automatic expect_predicted(input string name, input int expected);
        assert (pred_seen == expected)
        else
        begin
            value_errors++;
            $display("[FAIL] %s predicted items: expected %0d actual %0d", name, expected,
                     pred_seen);
        end
    endtask

    initial
    begin
        i_reset_n        = 1'b1;
        i_fetch_ready    = 1'b0;
        i_redirect_valid = 1'b0;
        i_redirect_pc    = '0;
        i_update_valid   = 1'b0;
        i_update_pc      = '0;
        i_update_target  = '0;
        i_update_taken   = 1'b0;
        i_imem_wr_en     = 1'b0;
        i_imem_wr_addr   = '0;
        i_imem_wr_data   = '0;
        lfsr_state       = 32'had8c_4353;
        exp_pc           = `RV_RESET_VECTOR;
        m_valid          = '0;
        m_rr             = 0;
        value_errors     = 0;
        hold_errors      = 0;
        reset_errors     = 0;
        timeout_errors   = 0;
        timed_out        = 1'b0;
        was_stalled      = 1'b0;
        was_redirect     = 1'b0;
        test_name        = "reset";

        // the program goes in while the core is idle, then reset is pulsed
        for (int i = 0; i < IMEM_WORDS; i++)
        begin
            @(negedge i_clk);
            i_imem_wr_en   = 1'b1;
            i_imem_wr_addr = `RV_IMEM_ADDR_BITS'(i);
            i_imem_wr_data = (32'(i) << 2) ^ 32'hA5A5_0000;
        end
        @(negedge i_clk);
        i_imem_wr_en = 1'b0;
        i_reset_n    = 1'b0;
        repeat (16) @(negedge i_clk);
        i_reset_n = 1'b1;

        accept_items("reset_seq", 20, 1'b0);
        expect_predicted("reset_seq", 0);
        accept_items("backpressure", 80, 1'b1);

        wait_for_valid_stalled("redirect_held");
        redirect_to(32'h0000_0200);
        accept_items("redirect_held", 12, 1'b1);
        // the second redirect lands while the output is still empty
        redirect_to(32'h0000_0080);
        redirect_to(32'h0000_03F0);
        accept_items("redirect_empty", 12, 1'b1);

        train(32'h0000_0140, 32'h0000_0300, 1'b1);
        redirect_to(32'h0000_0130);
        accept_items("predict_taken", 12, 1'b1);
        expect_predicted("predict_taken", 1);
        train(32'h0000_0140, 32'h0000_0300, 1'b0);
        train(32'h0000_0140, 32'h0000_0300, 1'b0);
        redirect_to(32'h0000_0130);
        accept_items("predict_off", 12, 1'b1);
        expect_predicted("predict_off", 0);

        // each of these branches jumps 8 bytes ahead and falls through to the next one
        for (int i = 0; i < 17; i++)
        begin
            train(pc_t'(32'h200 + 16 * i), pc_t'(32'h208 + 16 * i), 1'b1);
        end
        redirect_to(32'h0000_01FC);
        accept_items("replace", 60, 1'b1);
        expect_predicted("replace", 16);
        train(32'h0000_0250, 32'h0000_0254, 1'b1);
        redirect_to(32'h0000_01FC);
        accept_items("retrain", 60, 1'b1);
        expect_predicted("retrain", 16);

        $display("value errors %0d, hold errors %0d, reset errors %0d, timeouts %0d",
                 value_errors, hold_errors, reset_errors, timeout_errors);
        if (value_errors + hold_errors + reset_errors + timeout_errors == 0)
        begin
            $display("ALL CHECKS PASSED");
        end
        else
        begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rv_fetch.f */
+incdir+.
rv_fetch_pkg.sv
rv_fetch_branch_pred.sv
rv_fetch_imem.sv
rv_fetch_pc_gen.sv
rv_fetch_top.sv
tb_rv_fetch.sv
